//--- hw/rsp_pkg.sv
// Radar stage-2 prep shared widths, tagged sample structs and chirp state enum
package rsp_pkg;

  // --------------------
  // Widths
  // --------------------

  // I, Q and magnitude width
  localparam int sample_w = 16;
  // Range-bin index, 256 bins per chirp at most
  localparam int bin_w = 8;
  // Detection count, one extra bit so a full chirp of hits fits
  localparam int cnt_w = bin_w + 1;

  // --------------------
  // Inter-block payloads
  // --------------------

  // Complex sample tagged with its range bin, 41 bits
  typedef struct packed {
    logic signed [sample_w-1:0] re;
    logic signed [sample_w-1:0] im;
    logic [bin_w-1:0]           bin;
    logic                       last;
  } iq_sample_t;

  // Magnitude estimate with the same tag, 25 bits
  typedef struct packed {
    logic [sample_w-1:0] mag;
    logic [bin_w-1:0]    bin;
    logic                last;
  } mag_sample_t;

  // End-of-chirp summary, 33 bits
  typedef struct packed {
    logic [sample_w-1:0] peak_mag;
    logic [bin_w-1:0]    peak_bin;
    logic [cnt_w-1:0]    hit_count;
  } peak_report_t;

  // Input side chirp tracking
  typedef enum logic {chirp_idle, chirp_active} chirp_state_e;

endpackage

//--- hw/rsp_sample_in.sv
// Input side of the prep path, registers I/Q samples and tags range bin and last bin
`timescale 1ns/10ps

module rsp_sample_in import rsp_pkg::*; #(
  parameter int num_bins = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  logic                       chirp_start,
  input  logic signed [sample_w-1:0] in_re,
  input  logic signed [sample_w-1:0] in_im,
  output logic                       tag_valid,
  output iq_sample_t                 tag_out
);

  // Index of the final bin in a chirp
  localparam logic [bin_w-1:0] last_bin = bin_w'(num_bins - 1);

  chirp_state_e     state;
  logic [bin_w-1:0] bin_cnt;
  logic             accept;
  logic [bin_w-1:0] bin_now;
  logic             is_last;

  // --------------------
  // Accept and tag
  // --------------------

  // Idle drops samples until a chirp start, a start mid-chirp restarts
  assign accept  = in_valid && (chirp_start || (state == chirp_active));
  assign bin_now = chirp_start ? '0 : bin_cnt;
  assign is_last = (bin_now == last_bin);

  // Chirp state and bin counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= chirp_idle;
      bin_cnt   <= '0;
      tag_valid <= 1'b0;
    end else begin
      tag_valid <= accept;
      if (accept) begin
        bin_cnt <= bin_now + 1'b1;
        // Back to idle after the final bin
        state   <= is_last ? chirp_idle : chirp_active;
      end
    end
  end

  // Sample and tag register, payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      tag_out.re   <= in_re;
      tag_out.im   <= in_im;
      tag_out.bin  <= bin_now;
      tag_out.last <= is_last;
    end
  end

endmodule

//--- hw/rsp_abs_jpl.sv
// JPL magnitude estimator, four register stages with the bin tag carried alongside
`timescale 1ns/10ps

module rsp_abs_jpl import rsp_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tag_valid,
  input  iq_sample_t  tag_in,
  output logic        mag_valid,
  output mag_sample_t mag_out
);

  // Saturation codes
  localparam logic signed [sample_w-1:0] most_neg = {1'b1, {(sample_w-1){1'b0}}};
  localparam logic [sample_w-1:0]        max_pos  = {1'b0, {(sample_w-1){1'b1}}};

  logic [sample_w-1:0] abs_re;
  logic [sample_w-1:0] abs_im;
  logic [sample_w-1:0] u_max;
  logic [sample_w-1:0] v_min;
  logic [sample_w-1:0] u_r1;
  logic [sample_w-1:0] v_r1;
  logic [sample_w-1:0] v_r2;
  logic [sample_w-1:0] sum0_r1;
  logic [sample_w-1:0] sum0_r2;
  logic [sample_w-1:0] sum1_r1;
  logic [sample_w-1:0] sum1_r2;
  logic [sample_w-1:0] mag_r;
  logic [3:0]          vld_sr;
  logic [3:0]          last_sr;
  logic [bin_w-1:0]    bin_sr [4];

  // Absolute value, most negative code clamps to max positive
  function automatic logic [sample_w-1:0] abs_sat(input logic signed [sample_w-1:0] x);
    logic [sample_w-1:0] r;
    if (!x[sample_w-1]) begin
      r = x;
    end else if (x == most_neg) begin
      r = max_pos;
    end else begin
      r = -x;
    end
    return r;
  endfunction

  // --------------------
  // Stage 1 abs and sort
  // --------------------
  assign abs_re = abs_sat(tag_in.re);
  assign abs_im = abs_sat(tag_in.im);
  // U larger, V smaller
  assign u_max  = (abs_im > abs_re) ? abs_im : abs_re;
  assign v_min  = (abs_im > abs_re) ? abs_re : abs_im;

  // --------------------
  // Data pipeline
  // --------------------
  always_ff @(posedge clk) begin
    u_r1    <= u_max;
    v_r1    <= v_min;
    // Stage 2, U + V/8 and 7U/8 first half
    sum0_r1 <= u_r1 + (v_r1 >> 3);
    sum1_r1 <= u_r1 - (u_r1 >> 3);
    v_r2    <= v_r1;
    // Stage 3, add V/2 to the 7U/8 branch
    sum0_r2 <= sum0_r1;
    sum1_r2 <= sum1_r1 + (v_r2 >> 1);
    // Stage 4, larger candidate wins
    mag_r   <= (sum0_r2 > sum1_r2) ? sum0_r2 : sum1_r2;
  end

  // Valid strobe, four deep
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[2:0], tag_valid};
    end
  end

  // Bin and last tags follow the strobe
  always_ff @(posedge clk) begin
    bin_sr[0] <= tag_in.bin;
    for (int i = 1; i < 4; i++) begin
      bin_sr[i] <= bin_sr[i-1];
    end
    last_sr <= {last_sr[2:0], tag_in.last};
  end

  assign mag_valid    = vld_sr[3];
  assign mag_out.mag  = mag_r;
  assign mag_out.bin  = bin_sr[3];
  assign mag_out.last = last_sr[3];

endmodule

//--- hw/rsp_peak_track.sv
// Threshold detection and per-chirp peak search with an end-of-chirp report
`timescale 1ns/10ps

module rsp_peak_track import rsp_pkg::*; #(
  parameter int num_bins = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                mag_valid,
  input  mag_sample_t         mag_in,
  input  logic [sample_w-1:0] threshold,
  output logic                det,
  output logic                report_valid,
  output peak_report_t        report
);

  // Bins expected in a complete chirp
  localparam logic [cnt_w-1:0] full_count = cnt_w'(num_bins);

  logic [sample_w-1:0] peak_mag;
  logic [bin_w-1:0]    peak_bin;
  logic [cnt_w-1:0]    hit_cnt;
  logic [cnt_w-1:0]    seen_cnt;
  logic                first;
  logic                take;
  logic [sample_w-1:0] peak_mag_nxt;
  logic [bin_w-1:0]    peak_bin_nxt;
  logic [cnt_w-1:0]    hit_cnt_nxt;
  logic [cnt_w-1:0]    seen_cnt_nxt;

  // Strictly above threshold
  assign det = mag_valid && (mag_in.mag > threshold);

  // --------------------
  // Running values
  // --------------------

  // Bin 0 opens a new chirp, drops any abandoned partial one
  assign first = (mag_in.bin == '0);
  // Strict compare keeps the earlier bin on ties
  assign take  = first || (mag_in.mag > peak_mag);

  assign peak_mag_nxt = take ? mag_in.mag : peak_mag;
  assign peak_bin_nxt = take ? mag_in.bin : peak_bin;
  assign hit_cnt_nxt  = (first ? '0 : hit_cnt) + cnt_w'(det);
  assign seen_cnt_nxt = (first ? '0 : seen_cnt) + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peak_mag     <= '0;
      peak_bin     <= '0;
      hit_cnt      <= '0;
      seen_cnt     <= '0;
      report_valid <= 1'b0;
    end else begin
      report_valid <= 1'b0;
      if (mag_valid && mag_in.last) begin
        // Short chirp means lost samples, no report
        report_valid <= (seen_cnt_nxt == full_count);
        peak_mag     <= '0;
        peak_bin     <= '0;
        hit_cnt      <= '0;
        seen_cnt     <= '0;
      end else if (mag_valid) begin
        peak_mag <= peak_mag_nxt;
        peak_bin <= peak_bin_nxt;
        hit_cnt  <= hit_cnt_nxt;
        seen_cnt <= seen_cnt_nxt;
      end
    end
  end

  // Summary captured on the last bin
  always_ff @(posedge clk) begin
    if (mag_valid && mag_in.last) begin
      report.peak_mag  <= peak_mag_nxt;
      report.peak_bin  <= peak_bin_nxt;
      report.hit_count <= hit_cnt_nxt;
    end
  end

endmodule

//--- hw/rsp_prep_top.sv
// Stage-2 prep path top, chains sample input, JPL magnitude and peak tracking
`timescale 1ns/10ps

module rsp_prep_top import rsp_pkg::*; #(
  parameter int num_bins = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  logic                       chirp_start,
  input  logic signed [sample_w-1:0] in_re,
  input  logic signed [sample_w-1:0] in_im,
  input  logic [sample_w-1:0]        threshold,
  output logic                       mag_valid,
  output mag_sample_t                mag_out,
  output logic                       det,
  output logic                       report_valid,
  output peak_report_t               report
);

  // Tagged samples into the estimator
  logic       tag_valid;
  iq_sample_t tag_out;

  // Gate and tag, 1 cycle
  rsp_sample_in #(.num_bins(num_bins)) sample_in_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .chirp_start(chirp_start),
    .in_re      (in_re),
    .in_im      (in_im),
    .tag_valid  (tag_valid),
    .tag_out    (tag_out)
  );

  // Magnitude, 4 cycles
  rsp_abs_jpl abs_jpl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tag_valid(tag_valid),
    .tag_in   (tag_out),
    .mag_valid(mag_valid),
    .mag_out  (mag_out)
  );

  // Detection and chirp report
  rsp_peak_track #(.num_bins(num_bins)) peak_track_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mag_valid   (mag_valid),
    .mag_in      (mag_out),
    .threshold   (threshold),
    .det         (det),
    .report_valid(report_valid),
    .report      (report)
  );

endmodule

//--- verification/rsp_prep_properties.sv
// Bound checks on strobe timing and reset behavior of the prep path top
`timescale 1ns/10ps

module rsp_prep_properties (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic tag_valid,
  input logic mag_valid,
  input logic report_valid
);

  // Failed checks, read by the testbench summary
  int fail_cnt = 0;

  // --------------------
  // Strobe timing
  // --------------------

  // Tag strobe only from an input strobe one cycle back
  a_tag_from_input: assert property (@(posedge clk) disable iff (!rst_n)
    tag_valid |-> $past(in_valid))
    else begin
      fail_cnt++;
      $error("tag_valid without in_valid one cycle earlier");
    end

  // Estimator latency fixed at 4, so accepted input to output is 5
  a_mag_after_tag: assert property (@(posedge clk) disable iff (!rst_n)
    mag_valid == $past(tag_valid, 4))
    else begin
      fail_cnt++;
      $error("mag_valid does not match tag_valid from 4 cycles earlier");
    end

  a_mag_from_input: assert property (@(posedge clk) disable iff (!rst_n)
    mag_valid |-> $past(in_valid, 5))
    else begin
      fail_cnt++;
      $error("mag_valid without in_valid 5 cycles earlier");
    end

  // Single-cycle report pulse
  a_report_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    report_valid |-> !$past(report_valid))
    else begin
      fail_cnt++;
      $error("report_valid high on two consecutive cycles");
    end

  // --------------------
  // Reset
  // --------------------
  a_reset_quiet: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> (!mag_valid && !report_valid))
    else begin
      fail_cnt++;
      $error("output strobe high during reset or on the first cycle after it");
    end

endmodule

bind rsp_prep_top rsp_prep_properties props_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_valid    (in_valid),
  .tag_valid   (tag_valid),
  .mag_valid   (mag_valid),
  .report_valid(report_valid)
);

//--- verification/rsp_prep_tb.sv
// Testbench for the stage-2 prep path, JPL reference model with per-sample and report checks
`timescale 1ns/10ps

module rsp_prep_tb import rsp_pkg::*; ();

  localparam int nb     = 16;
  localparam int period = 100;
  // Worst-case cycles per test, then margin
  localparam int run_cycles = 16 + 30 + 45 + 140 + 30 + 55 + 45 + 200;

  logic clk = 1'b0;
  logic rst_n;
  logic in_valid;
  logic chirp_start;
  logic signed [sample_w-1:0] in_re;
  logic signed [sample_w-1:0] in_im;
  logic [sample_w-1:0] threshold;
  logic mag_valid;
  logic det;
  logic report_valid;
  mag_sample_t  mag_out;
  peak_report_t report;

  // Reference model state
  int seed = 32'h26fd_2e22;
  bit active;
  int next_bin;
  int pk_mag;
  int pk_bin;
  int hits;
  int seen;
  int errors;
  int checks;
  logic [sample_w-1:0] thr;
  mag_sample_t  exp_q[$];
  bit           det_q[$];
  peak_report_t rep_q[$];

  rsp_prep_top #(.num_bins(nb)) dut_i (.*);

  always #(period / 2) clk = ~clk;

  // --------------------
  // Reference model
  // --------------------

  // JPL estimate, larger of U + V/8 and U - U/8 + V/2
  function automatic int jpl_ref(input int re, input int im);
    int a;
    int b;
    int u;
    int v;
    int c0;
    int c1;
    a = (re < 0) ? -re : re;
    b = (im < 0) ? -im : im;
    // Most negative code saturates
    a = (a > 32767) ? 32767 : a;
    b = (b > 32767) ? 32767 : b;
    u = (a > b) ? a : b;
    v = (a > b) ? b : a;
    c0 = u + v / 8;
    c1 = u - u / 8 + v / 2;
    return (c0 > c1) ? c0 : c1;
  endfunction

  // Gate, tag and queue one strobed sample
  task automatic model_sample(input bit start, input int re, input int im);
    mag_sample_t m;
    int bin;
    if (!(start || active)) begin
      return;
    end
    bin = start ? 0 : next_bin;
    m.mag  = 16'(jpl_ref(re, im));
    m.bin  = 8'(bin);
    m.last = (bin == nb - 1);
    exp_q.push_back(m);
    det_q.push_back(m.mag > thr);
    // Bin 0 opens a fresh summary, ties keep the earlier bin
    if (bin == 0 || m.mag > pk_mag) begin
      pk_mag = m.mag;
      pk_bin = bin;
    end
    hits = (bin == 0) ? 0 : hits;
    seen = (bin == 0) ? 1 : seen + 1;
    if (m.mag > thr) begin
      hits++;
    end
    if (m.last && seen == nb) begin
      rep_q.push_back({16'(pk_mag), 8'(pk_bin), 9'(hits)});
    end
    active   = !m.last;
    next_bin = bin + 1;
  endtask

  // --------------------
  // Stimulus
  // --------------------

  task automatic drive(input bit vld, input bit start, input int re, input int im);
    @(posedge clk);
    in_valid    <= vld;
    chirp_start <= start;
    in_re       <= 16'(re);
    in_im       <= 16'(im);
    if (vld) begin
      model_sample(start, re, im);
    end
  endtask

  // Random I/Q, chirp start on the first, up to gap_max idle cycles between
  task automatic send_chirp(input int gap_max, input int count);
    logic signed [sample_w-1:0] r;
    logic signed [sample_w-1:0] i;
    for (int k = 0; k < count; k++) begin
      r = 16'($random(seed));
      i = 16'($random(seed));
      drive(1'b1, k == 0, r, i);
      repeat ({$random(seed)} % (gap_max + 1)) drive(1'b0, 1'b0, 0, 0);
    end
  endtask

  task automatic set_threshold(input logic [sample_w-1:0] v);
    @(posedge clk);
    threshold <= v;
    thr = v;
  endtask

  // Mid-stream reset, pending expectations die with the pipeline
  task automatic apply_reset(input int cycles);
    @(posedge clk);
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    repeat (cycles) @(posedge clk);
    exp_q.delete();
    det_q.delete();
    rep_q.delete();
    active = 1'b0;
    rst_n <= 1'b1;
  endtask

  // Drain the pipeline, then one line per test
  task automatic end_test(input string name, input int err_before);
    while (exp_q.size() > 0 || rep_q.size() > 0) begin
      drive(1'b0, 1'b0, 0, 0);
    end
    repeat (3) drive(1'b0, 1'b0, 0, 0);
    $display("Test %s finished, %0d errors", name, errors - err_before);
  endtask

  // --------------------
  // Output checks
  // --------------------

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    mag_sample_t  em;
    peak_report_t er;
    bit           ed;
    if (rst_n) begin
      if (mag_valid && exp_q.size() == 0) begin
        $display("Unexpected mag_valid at %0t with no sample pending", $time);
        errors++;
      end else if (mag_valid) begin
        em = exp_q.pop_front();
        ed = det_q.pop_front();
        checks++;
        assert (mag_out == em) else begin
          $display("Fail at %0t: mag_out exp=%h got=%h", $time, em, mag_out);
          errors++;
        end
        assert (det == ed) else begin
          $display("Fail at %0t: det exp=%0b got=%0b", $time, ed, det);
          errors++;
        end
      end else begin
        assert (!det) else begin
          $display("Detection flag raised at %0t without mag_valid", $time);
          errors++;
        end
      end
      if (report_valid && rep_q.size() == 0) begin
        $display("Unexpected report_valid at %0t with no report pending", $time);
        errors++;
      end else if (report_valid) begin
        er = rep_q.pop_front();
        checks++;
        assert (report == er) else begin
          $display("Fail at %0t: report exp=%h got=%h", $time, er, report);
          errors++;
        end
      end
    end
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int e0;
    int cre[16] = '{0, 1000, 0, -1000, 0, 500, -500, -32768,
                    0, -32768, 32767, 123, -1, 7, -32767, 1};
    int cim[16] = '{0, 0, 1000, 0, -1000, 500, -500, 0,
                    -32768, -32768, -32768, -4567, 1, 3, 32767, -1};
    in_valid    = 1'b0;
    chirp_start = 1'b0;
    in_re       = '0;
    in_im       = '0;
    threshold   = '0;
    rst_n       = 1'b0;
    thr         = '0;
    active      = 1'b0;
    errors      = 0;
    checks      = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Zero, axes, diagonals, signs and saturating codes
    e0 = errors;
    set_threshold(16'd20000);
    for (int k = 0; k < nb; k++) begin
      drive(1'b1, k == 0, cre[k], cim[k]);
    end
    end_test("corner_magnitudes", e0);

    e0 = errors;
    send_chirp(0, nb);
    send_chirp(0, nb);
    end_test("back_to_back_chirps", e0);

    e0 = errors;
    send_chirp(3, nb);
    send_chirp(3, nb);
    end_test("gapped_input", e0);

    // Peaks of 4000 at bins 4, 9, 14 and 3000 exactly at threshold
    e0 = errors;
    set_threshold(16'(jpl_ref(3000, 0)));
    for (int k = 0; k < nb; k++) begin
      drive(1'b1, k == 0, (k % 5) * 1000, 0);
    end
    end_test("detection_and_ties", e0);

    // Dropped before any start, then a restart mid-chirp
    e0 = errors;
    set_threshold(16'd20000);
    repeat (3) drive(1'b1, 1'b0, 1234, -77);
    send_chirp(0, 6);
    send_chirp(1, nb);
    end_test("idle_drop_and_restart", e0);

    e0 = errors;
    send_chirp(0, 7);
    apply_reset(8);
    send_chirp(0, nb);
    end_test("reset_mid_stream", e0);

    $display("Summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
             checks, errors, dut_i.props_i.fail_cnt);
    if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(run_cycles * period);
    $display("Watchdog expired, tests did not finish within %0d cycles", run_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- project.f
hw/rsp_pkg.sv
hw/rsp_sample_in.sv
hw/rsp_abs_jpl.sv
hw/rsp_peak_track.sv
hw/rsp_prep_top.sv
verification/rsp_prep_properties.sv
verification/rsp_prep_tb.sv

//--- Makefile
# Verilator build and run for the stage-2 prep path testbench

VERILATOR ?= verilator
TOP       ?= rsp_prep_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
